//--- src/compress_consts.svh
`ifndef COMPRESS_CONSTS_SVH
`define COMPRESS_CONSTS_SVH

// Coefficients fetched from memory per clock
`define COEFF_PER_CLK 4

// ML-KEM modulus and the width it needs
`define Q_VALUE 3329
`define Q_WIDTH 12

// One coefficient memory slot, only the low Q_WIDTH bits carry data
`define REG_SIZE 24

`define MEM_ADDR_WIDTH 14
`define DATA_WIDTH 32

// 256 coefficients at four per read
`define READS_PER_POLY 64

// Packer storage and the fill level that pauses the reader
`define PACK_CAPACITY 192
`define PACK_FULL_LEVEL 48

`endif

//--- src/compress_pkg.sv
`default_nettype none

`include "compress_consts.svh"

package compress_pkg;

    typedef logic [`Q_WIDTH-1:0] coeff_t;

    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    typedef logic [`DATA_WIDTH-1:0] api_word_t;

    // Four lanes of up to 12 bits each
    typedef logic [`COEFF_PER_CLK*`Q_WIDTH-1:0] chunk_t;

    // Fill level of the packer, or the width of one chunk
    typedef logic [7:0] bit_count_t;

    // Output width d of the compression
    typedef enum logic [1:0] {
        compress1  = 2'd0,
        compress5  = 2'd1,
        compress11 = 2'd2,
        compress12 = 2'd3
    } compress_mode_t;

endpackage

`default_nettype wire

//--- src/compress_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_read_ctrl (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       zeroize_i,
    input  wire                       start_i,
    input  wire [2:0]                 num_poly_i,
    input  compress_pkg::mem_addr_t   src_base_addr_i,
    input  wire                       pause_i,
    output logic                      mem_rd_en_o,
    output compress_pkg::mem_addr_t   mem_rd_addr_o,
    output logic                      rd_valid_o,
    output logic                      read_done_o
);

    localparam int RD_CNT_W = $clog2(`READS_PER_POLY);

    typedef enum logic [1:0] {idle, reading, done} rd_state_t;

    rd_state_t           state;
    logic [RD_CNT_W-1:0] rd_cnt;
    logic [2:0]          poly_cnt;

    // A read goes out every cycle of the reading state unless the packer is full
    assign mem_rd_en_o = (state == reading) && !pause_i;
    assign read_done_o = (state == done);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= idle;
            rd_cnt        <= '0;
            poly_cnt      <= '0;
            mem_rd_addr_o <= '0;
            rd_valid_o    <= 1'b0;
        end else if (zeroize_i) begin
            state         <= idle;
            rd_cnt        <= '0;
            poly_cnt      <= '0;
            mem_rd_addr_o <= '0;
            rd_valid_o    <= 1'b0;
        end else begin
            // Memory answers one cycle after the request
            rd_valid_o <= mem_rd_en_o;
            if (start_i) begin
                state         <= reading;
                rd_cnt        <= '0;
                poly_cnt      <= '0;
                mem_rd_addr_o <= src_base_addr_i;
            end else if (mem_rd_en_o) begin
                mem_rd_addr_o <= mem_rd_addr_o + 1'b1;
                rd_cnt        <= rd_cnt + 1'b1;
                if (rd_cnt == RD_CNT_W'(`READS_PER_POLY - 1)) begin
                    if (poly_cnt == num_poly_i - 3'd1) begin
                        state <= done;
                    end else begin
                        poly_cnt <= poly_cnt + 3'd1;
                    end
                end
            end
        end
    end

    // A paused cycle issues nothing and leaves the address for the retry
    pause_holds_read: assert property (@(posedge clk) disable iff (!reset_n)
        (state == reading && pause_i && !start_i && !zeroize_i)
            |=> ($stable(mem_rd_addr_o) && !rd_valid_o));

endmodule

`default_nettype wire

//--- src/compress_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_unit (
    input  compress_pkg::coeff_t         op_i,
    input  compress_pkg::compress_mode_t mode_i,
    output compress_pkg::coeff_t         op_o
);

    import compress_pkg::*;

    // Wide enough for x * 2^11 plus q/2
    localparam int NUM_W = 2 * `Q_WIDTH;

    logic [NUM_W-1:0] scaled;
    logic [NUM_W-1:0] quot;

    always_comb begin
        scaled = NUM_W'(op_i);
        unique case (mode_i)
            compress1:  scaled = NUM_W'(op_i) << 1;
            compress5:  scaled = NUM_W'(op_i) << 5;
            compress11: scaled = NUM_W'(op_i) << 11;
            compress12: scaled = NUM_W'(op_i);
        endcase
        // Adding q/2 before the division rounds to nearest
        quot = (scaled + NUM_W'(`Q_VALUE / 2)) / NUM_W'(`Q_VALUE);
    end

    // Keeping only d bits gives the mod 2^d
    always_comb begin
        op_o = op_i;
        unique case (mode_i)
            compress1:  op_o = coeff_t'(quot[0]);
            compress5:  op_o = coeff_t'(quot[4:0]);
            compress11: op_o = coeff_t'(quot[10:0]);
            compress12: op_o = op_i;
        endcase
    end

endmodule

`default_nettype wire

//--- src/compress_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_lanes (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize_i,
    input  compress_pkg::compress_mode_t          mode_i,
    input  wire                                   valid_i,
    input  wire [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0] data_i,
    output compress_pkg::chunk_t                  chunk_o,
    output compress_pkg::bit_count_t              chunk_bits_o
);

    import compress_pkg::*;

    coeff_t     coeff [`COEFF_PER_CLK];
    coeff_t     res   [`COEFF_PER_CLK];
    chunk_t     chunk_d;
    bit_count_t bits_d;

    for (genvar i = 0; i < `COEFF_PER_CLK; i++) begin : g_lane
        assign coeff[i] = data_i[i][`Q_WIDTH-1:0];

        compress_unit i_compress_unit (
            .op_i   (coeff[i]),
            .mode_i (mode_i),
            .op_o   (res[i])
        );

        // Memory content must already be reduced mod q
        coeff_in_range: assert property (@(posedge clk) disable iff (!reset_n)
            valid_i |-> (coeff[i] < `Q_WIDTH'(`Q_VALUE)));
    end

    // Lane 0 sits in the lowest bits, upper bits stay zero
    always_comb begin
        chunk_d = {res[3], res[2], res[1], res[0]};
        bits_d  = bit_count_t'(`COEFF_PER_CLK * `Q_WIDTH);
        unique case (mode_i)
            compress1: begin
                chunk_d = chunk_t'({res[3][0], res[2][0], res[1][0], res[0][0]});
                bits_d  = bit_count_t'(`COEFF_PER_CLK * 1);
            end
            compress5: begin
                chunk_d = chunk_t'({res[3][4:0], res[2][4:0], res[1][4:0], res[0][4:0]});
                bits_d  = bit_count_t'(`COEFF_PER_CLK * 5);
            end
            compress11: begin
                chunk_d = chunk_t'({res[3][10:0], res[2][10:0], res[1][10:0], res[0][10:0]});
                bits_d  = bit_count_t'(`COEFF_PER_CLK * 11);
            end
            compress12: begin
                chunk_d = {res[3], res[2], res[1], res[0]};
                bits_d  = bit_count_t'(`COEFF_PER_CLK * `Q_WIDTH);
            end
        endcase
    end

    // A zero width tells the packer there is nothing to take
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chunk_o      <= '0;
            chunk_bits_o <= '0;
        end else if (zeroize_i) begin
            chunk_o      <= '0;
            chunk_bits_o <= '0;
        end else begin
            chunk_o      <= chunk_d;
            chunk_bits_o <= valid_i ? bits_d : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/compress_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_packer (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      zeroize_i,
    input  compress_pkg::chunk_t     chunk_i,
    input  compress_pkg::bit_count_t chunk_bits_i,
    output logic                     full_o,
    output logic                     word_valid_o,
    output compress_pkg::api_word_t  word_o,
    output logic                     empty_o
);

    import compress_pkg::*;

    localparam int CAP = `PACK_CAPACITY;

    logic [CAP-1:0] acc;
    logic [CAP-1:0] acc_next;
    bit_count_t     count;
    bit_count_t     count_kept;
    bit_count_t     count_next;
    chunk_t         chunk_masked;

    // Stored bits are kept right aligned, so the oldest word is always at the bottom
    assign word_valid_o = (count >= bit_count_t'(`DATA_WIDTH));
    assign word_o       = acc[`DATA_WIDTH-1:0];
    assign full_o       = (count >= bit_count_t'(`PACK_FULL_LEVEL));
    assign empty_o      = (count == '0);

    always_comb begin
        // Chunk bits above the reported width are not trusted
        chunk_masked = chunk_i & ~({$bits(chunk_t){1'b1}} << chunk_bits_i);
        if (word_valid_o) begin
            acc_next   = acc >> `DATA_WIDTH;
            count_kept = count - bit_count_t'(`DATA_WIDTH);
        end else begin
            acc_next   = acc;
            count_kept = count;
        end
        // New chunk lands just above what stays behind
        acc_next   = acc_next | (CAP'(chunk_masked) << count_kept);
        count_next = count_kept + chunk_bits_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc   <= '0;
            count <= '0;
        end else if (zeroize_i) begin
            acc   <= '0;
            count <= '0;
        end else begin
            acc   <= acc_next;
            count <= count_next;
        end
    end

    // Holds only if the reader stops soon enough after full rises
    capacity_ok: assert property (@(posedge clk) disable iff (!reset_n)
        count_next <= bit_count_t'(CAP));

endmodule

`default_nettype wire

//--- src/compress_api_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_api_port (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       zeroize_i,
    input  wire                       start_i,
    input  compress_pkg::mem_addr_t   dest_base_addr_i,
    input  wire                       compare_mode_i,
    input  wire                       word_valid_i,
    input  compress_pkg::api_word_t   word_i,
    input  compress_pkg::api_word_t   api_rd_data_i,
    output logic                      api_wr_en_o,
    output logic                      api_rd_en_o,
    output compress_pkg::mem_addr_t   api_addr_o,
    output compress_pkg::api_word_t   api_wr_data_o,
    output logic                      compare_failed_o,
    output logic                      pending_o
);

    import compress_pkg::*;

    logic      cmp_valid;
    api_word_t cmp_word;

    // Each packed word is taken in the cycle it appears
    assign api_wr_en_o   = word_valid_i && !compare_mode_i;
    assign api_rd_en_o   = word_valid_i && compare_mode_i;
    assign api_wr_data_o = word_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            api_addr_o <= '0;
            cmp_valid  <= 1'b0;
            cmp_word   <= '0;
        end else if (zeroize_i) begin
            api_addr_o <= '0;
            cmp_valid  <= 1'b0;
            cmp_word   <= '0;
        end else begin
            cmp_valid <= api_rd_en_o;
            // Expected word waits one cycle for the read data
            if (api_rd_en_o) begin
                cmp_word <= word_i;
            end
            if (start_i) begin
                api_addr_o <= dest_base_addr_i;
            end else if (api_wr_en_o || api_rd_en_o) begin
                api_addr_o <= api_addr_o + 1'b1;
            end
        end
    end

    assign compare_failed_o = cmp_valid && (cmp_word != api_rd_data_i);
    assign pending_o        = cmp_valid;

endmodule

`default_nettype wire

//--- src/compress_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module compress_top (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize_i,
    input  wire                                   compress_enable_i,
    input  compress_pkg::compress_mode_t          mode_i,
    input  wire                                   compare_mode_i,
    input  wire [2:0]                             num_poly_i,
    input  compress_pkg::mem_addr_t               src_base_addr_i,
    input  compress_pkg::mem_addr_t               dest_base_addr_i,
    input  wire [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0] mem_rd_data_i,
    input  compress_pkg::api_word_t               api_rd_data_i,
    output logic                                  mem_rd_en_o,
    output compress_pkg::mem_addr_t               mem_rd_addr_o,
    output logic                                  api_wr_en_o,
    output logic                                  api_rd_en_o,
    output compress_pkg::mem_addr_t               api_addr_o,
    output compress_pkg::api_word_t               api_wr_data_o,
    output logic                                  compare_failed_o,
    output logic                                  compress_done_o
);

    import compress_pkg::*;

    logic       busy;
    logic       rd_valid;
    logic       read_done;
    chunk_t     chunk;
    bit_count_t chunk_bits;
    logic       pack_full;
    logic       pack_empty;
    logic       word_valid;
    api_word_t  word;
    logic       cmp_pending;

    // Done once every stage of the pipeline has drained
    assign compress_done_o = busy && read_done && !mem_rd_en_o && !rd_valid
                             && (chunk_bits == '0) && pack_empty && !cmp_pending;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else if (zeroize_i) begin
            busy <= 1'b0;
        end else if (compress_enable_i) begin
            busy <= 1'b1;
        end else if (compress_done_o) begin
            busy <= 1'b0;
        end
    end

    compress_read_ctrl i_compress_read_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .start_i         (compress_enable_i),
        .num_poly_i      (num_poly_i),
        .src_base_addr_i (src_base_addr_i),
        .pause_i         (pack_full),
        .mem_rd_en_o     (mem_rd_en_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .rd_valid_o      (rd_valid),
        .read_done_o     (read_done)
    );

    compress_lanes i_compress_lanes (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .valid_i      (rd_valid),
        .data_i       (mem_rd_data_i),
        .chunk_o      (chunk),
        .chunk_bits_o (chunk_bits)
    );

    compress_packer i_compress_packer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .chunk_i      (chunk),
        .chunk_bits_i (chunk_bits),
        .full_o       (pack_full),
        .word_valid_o (word_valid),
        .word_o       (word),
        .empty_o      (pack_empty)
    );

    compress_api_port i_compress_api_port (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize_i        (zeroize_i),
        .start_i          (compress_enable_i),
        .dest_base_addr_i (dest_base_addr_i),
        .compare_mode_i   (compare_mode_i),
        .word_valid_i     (word_valid),
        .word_i           (word),
        .api_rd_data_i    (api_rd_data_i),
        .api_wr_en_o      (api_wr_en_o),
        .api_rd_en_o      (api_rd_en_o),
        .api_addr_o       (api_addr_o),
        .api_wr_data_o    (api_wr_data_o),
        .compare_failed_o (compare_failed_o),
        .pending_o        (cmp_pending)
    );

    // API memory sees either a write or a compare read, never both
    api_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(api_wr_en_o && api_rd_en_o));

endmodule

`default_nettype wire

//--- test/tb_compress_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "compress_consts.svh"

module tb_compress_top;

    import compress_pkg::*;

    localparam int MEM_DEPTH = 1 << `MEM_ADDR_WIDTH;
    // Reads of all six tests, with the interrupted command counted in full
    localparam int TOTAL_READS = 64 + 192 + 128 + 128 + 64 + 64 + 128 + 128;
    localparam int CYCLE_LIMIT = 4 * TOTAL_READS + 200;

    logic                                     clk;
    logic                                     reset_n;
    logic                                     zeroize_i;
    logic                                     compress_enable_i;
    compress_mode_t                           mode_i;
    logic                                     compare_mode_i;
    logic [2:0]                               num_poly_i;
    mem_addr_t                                src_base_addr_i;
    mem_addr_t                                dest_base_addr_i;
    logic [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0] mem_rd_data_i;
    api_word_t                                api_rd_data_i;
    logic                                     mem_rd_en_o;
    mem_addr_t                                mem_rd_addr_o;
    logic                                     api_wr_en_o;
    logic                                     api_rd_en_o;
    mem_addr_t                                api_addr_o;
    api_word_t                                api_wr_data_o;
    logic                                     compare_failed_o;
    logic                                     compress_done_o;

    logic [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0] coef_mem [MEM_DEPTH];
    api_word_t                                api_mem  [MEM_DEPTH];
    mem_addr_t                                coef_rd_addr;
    mem_addr_t                                api_rd_addr;

    api_word_t exp_words [$];
    mem_addr_t exp_base;
    int        exp_reads;
    int        word_idx;
    int        wr_cnt;
    int        rd_cnt;
    int        mem_rd_cnt;
    int        pause_cnt;
    int        fail_pulse_cnt;
    int        done_cnt;
    int        err_cnt;
    int        errs_before;
    int        test_cnt;
    int        bad_test_cnt;
    int        cycle_cnt;

    compress_top i_compress_top (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize_i         (zeroize_i),
        .compress_enable_i (compress_enable_i),
        .mode_i            (mode_i),
        .compare_mode_i    (compare_mode_i),
        .num_poly_i        (num_poly_i),
        .src_base_addr_i   (src_base_addr_i),
        .dest_base_addr_i  (dest_base_addr_i),
        .mem_rd_data_i     (mem_rd_data_i),
        .api_rd_data_i     (api_rd_data_i),
        .mem_rd_en_o       (mem_rd_en_o),
        .mem_rd_addr_o     (mem_rd_addr_o),
        .api_wr_en_o       (api_wr_en_o),
        .api_rd_en_o       (api_rd_en_o),
        .api_addr_o        (api_addr_o),
        .api_wr_data_o     (api_wr_data_o),
        .compare_failed_o  (compare_failed_o),
        .compress_done_o   (compress_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int mode_bits(input compress_mode_t m);
        case (m)
            compress1:  return 1;
            compress5:  return 5;
            compress11: return 11;
            default:    return 12;
        endcase
    endfunction

    // round(2^d x / q) written as floor((2^(d+1) x + q) / 2q), then mod 2^d
    function automatic logic [11:0] compress_ref(input logic [11:0] x, input int d);
        longint unsigned num;
        longint unsigned rounded;
        if (d == 12) begin
            return x;
        end
        num     = (64'(x) << (d + 1)) + 64'(`Q_VALUE);
        rounded = num / 64'(2 * `Q_VALUE);
        return 12'(rounded % (64'd1 << d));
    endfunction

    // Packs the reference results little endian into 32-bit words, lane 0 first
    function automatic void build_expected(input mem_addr_t src, input int n_poly,
                                           input compress_mode_t m);
        int          d;
        int          fill;
        logic [63:0] acc;
        logic [11:0] x;
        d    = mode_bits(m);
        fill = 0;
        acc  = '0;
        exp_words.delete();
        for (int a = 0; a < n_poly * `READS_PER_POLY; a++) begin
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                x    = coef_mem[int'(src) + a][l][`Q_WIDTH-1:0];
                acc  = acc | (64'(compress_ref(x, d)) << fill);
                fill = fill + d;
                if (fill >= 32) begin
                    exp_words.push_back(acc[31:0]);
                    acc  = acc >> 32;
                    fill = fill - 32;
                end
            end
        end
    endfunction

    // Slots hold a reduced coefficient below some noise in the unused upper bits
    initial begin : fill_coef_mem
        logic [31:0] seed;
        seed = 32'd95;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                seed           = lcg_next(seed);
                coef_mem[a][l] = {seed[15:4], 12'(seed[27:16] % `Q_WIDTH'(`Q_VALUE))};
            end
        end
    end

    // Both memories answer on the falling edge after the request
    always @(posedge clk) begin
        if (mem_rd_en_o) begin
            coef_rd_addr <= mem_rd_addr_o;
        end
        if (api_rd_en_o) begin
            api_rd_addr <= api_addr_o;
        end
        if (api_wr_en_o) begin
            api_mem[api_addr_o] <= api_wr_data_o;
        end
    end

    always @(negedge clk) begin
        mem_rd_data_i = coef_mem[coef_rd_addr];
        api_rd_data_i = api_mem[api_rd_addr];
    end

    task automatic check_access();
        mem_addr_t exp_addr;
        exp_addr = mem_addr_t'(int'(exp_base) + word_idx);
        assert (word_idx < exp_words.size()) else begin
            $display("Error at %0t: API access past the %0d expected words", $time,
                     exp_words.size());
            err_cnt++;
        end
        if (word_idx < exp_words.size()) begin
            assert (api_addr_o == exp_addr) else begin
                $display("CHECK FAILED at %0t: api_addr_o is %0d, expected %0d", $time,
                         api_addr_o, exp_addr);
                err_cnt++;
            end
            if (api_wr_en_o) begin
                assert (api_wr_data_o == exp_words[word_idx]) else begin
                    $display("CHECK FAILED at %0t: api_wr_data_o is %h, expected %h", $time,
                             api_wr_data_o, exp_words[word_idx]);
                    err_cnt++;
                end
            end
        end
        word_idx++;
    endtask

    always @(posedge clk) begin
        if (reset_n) begin
            if (mem_rd_en_o) begin
                mem_rd_cnt++;
            end else if (mem_rd_cnt > 0 && mem_rd_cnt < exp_reads) begin
                pause_cnt++;
            end
            if (api_wr_en_o) begin
                wr_cnt++;
            end
            if (api_rd_en_o) begin
                rd_cnt++;
            end
            if (api_wr_en_o || api_rd_en_o) begin
                check_access();
            end
            if (compare_failed_o) begin
                fail_pulse_cnt++;
            end
            if (compress_done_o) begin
                done_cnt++;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles without finishing the tests", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    task automatic check_count(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("CHECK FAILED at %0t: %s count is %0d, expected %0d", $time, name,
                     got, want);
            err_cnt++;
        end
    endtask

    task automatic check_low(input string name, input logic v);
        assert (v == 1'b0) else begin
            $display("CHECK FAILED at %0t: %s is %0b, expected 0", $time, name, v);
            err_cnt++;
        end
    endtask

    // Called on a falling edge; corrupts words 1, 7, 13 and so on in compare mode
    task automatic run_command(input compress_mode_t m, input logic cmp, input int n_poly,
                               input int src, input int dest, input int n_corrupt);
        build_expected(mem_addr_t'(src), n_poly, m);
        exp_base  = mem_addr_t'(dest);
        exp_reads = n_poly * `READS_PER_POLY;
        if (cmp) begin
            for (int i = 0; i < exp_words.size(); i++) begin
                if (i % 6 == 1 && i / 6 < n_corrupt) begin
                    api_mem[dest + i] <= exp_words[i] ^ 32'h8000_0001;
                end else begin
                    api_mem[dest + i] <= exp_words[i];
                end
            end
        end
        word_idx          = 0;
        wr_cnt            = 0;
        rd_cnt            = 0;
        mem_rd_cnt        = 0;
        pause_cnt         = 0;
        fail_pulse_cnt    = 0;
        done_cnt          = 0;
        mode_i            = m;
        compare_mode_i    = cmp;
        num_poly_i        = 3'(n_poly);
        src_base_addr_i   = mem_addr_t'(src);
        dest_base_addr_i  = mem_addr_t'(dest);
        compress_enable_i = 1'b1;
        @(negedge clk);
        compress_enable_i = 1'b0;
    endtask

    task automatic wait_done();
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        // A short quiet window that would show a second done pulse
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d, %s: ok", test_cnt, name);
        end else begin
            bad_test_cnt++;
            $display("test %0d, %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
        errs_before = err_cnt;
    endtask

    initial begin
        reset_n           = 1'b0;
        zeroize_i         = 1'b0;
        compress_enable_i = 1'b0;
        mode_i            = compress1;
        compare_mode_i    = 1'b0;
        num_poly_i        = '0;
        src_base_addr_i   = '0;
        dest_base_addr_i  = '0;
        mem_rd_data_i     = '0;
        api_rd_data_i     = '0;
        exp_reads         = 0;
        err_cnt           = 0;
        errs_before       = 0;
        test_cnt          = 0;
        bad_test_cnt      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        run_command(compress1, 1'b0, 1, 0, 100, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 8);
        check_count("compress_done_o", done_cnt, 1);
        end_test("compress1 with one polynomial");

        run_command(compress11, 1'b0, 3, 200, 1000, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 264);
        check_count("mem_rd_en_o", mem_rd_cnt, exp_reads);
        check_count("compress_done_o", done_cnt, 1);
        assert (pause_cnt > 0) else begin
            $display("Error at %0t: the reader never paused for back-pressure", $time);
            err_cnt++;
        end
        end_test("compress11 with back-pressure");

        run_command(compress5, 1'b0, 2, 400, 2000, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 80);
        check_count("compress_done_o", done_cnt, 1);
        run_command(compress12, 1'b0, 2, 600, 3000, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 192);
        check_count("compress_done_o", done_cnt, 1);
        end_test("compress5 and compress12");

        run_command(compress11, 1'b1, 1, 800, 4000, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 0);
        check_count("api_rd_en_o", rd_cnt, 88);
        check_count("compare_failed_o", fail_pulse_cnt, 0);
        check_count("compress_done_o", done_cnt, 1);
        end_test("compare against matching words");

        run_command(compress5, 1'b1, 1, 900, 5000, 3);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 0);
        check_count("api_rd_en_o", rd_cnt, 40);
        check_count("compare_failed_o", fail_pulse_cnt, 3);
        check_count("compress_done_o", done_cnt, 1);
        end_test("compare with three corrupted words");

        // Interrupt a command partway through its output
        run_command(compress12, 1'b0, 2, 1000, 6000, 0);
        while (wr_cnt < 10) begin
            @(negedge clk);
        end
        zeroize_i = 1'b1;
        @(negedge clk);
        check_low("mem_rd_en_o", mem_rd_en_o);
        check_low("api_wr_en_o", api_wr_en_o);
        check_low("api_rd_en_o", api_rd_en_o);
        check_low("compare_failed_o", compare_failed_o);
        check_low("compress_done_o", compress_done_o);
        check_count("compress_done_o", done_cnt, 0);
        zeroize_i = 1'b0;
        @(negedge clk);
        run_command(compress12, 1'b0, 2, 1000, 6000, 0);
        wait_done();
        check_count("api_wr_en_o", wr_cnt, 192);
        check_count("compress_done_o", done_cnt, 1);
        end_test("zeroize and restart");

        $display("%0d tests run, %0d with errors, %0d errors in all", test_cnt,
                 bad_test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/compress_pkg.sv
src/compress_read_ctrl.sv
src/compress_unit.sv
src/compress_lanes.sv
src/compress_packer.sv
src/compress_api_port.sv
src/compress_top.sv
test/tb_compress_top.sv

//--- Makefile
TOP = tb_compress_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
